// File: common/dram_pkg.sv
`default_nettype none

package dram_pkg;

    typedef logic [14:0] row_t;
    typedef logic [9:0]  col_t;
    typedef logic [1:0]  bank_t;
    typedef logic [1:0]  bg_t;
    typedef logic [13:0] addr_t;

    // pin order CS_n, ACT_n, RAS_n_A16, CAS_n_A15, WE_n_A14
    typedef enum logic [4:0] {
        DESEL_CMD     = 5'b11111,
        LOAD_MODE_CMD = 5'b01000,
        REFRESH_CMD   = 5'b01001,
        PRECHARGE_CMD = 5'b01010,
        ACT_CMD       = 5'b00000,
        WRITE_CMD     = 5'b01100,
        READ_CMD      = 5'b01101,
        ZQ_CMD        = 5'b01110,
        POWER_UP_PRG  = 5'b10000
    } cmd_t;

    // mode loads must stay contiguous, signal_gen indexes the table by offset
    typedef enum logic [4:0] {
        POWER_UP,
        PRE_RESET,
        RESET,
        NOP,
        LOAD_BG0_REG3,
        LOAD_BG1_REG6,
        LOAD_BG1_REG5,
        LOAD_BG1_REG4,
        LOAD_BG0_REG2,
        LOAD_BG0_REG1,
        LOAD_BG0_REG0,
        ZQ_CL,
        IDLE,
        ACTIVATE,
        WRITE,
        READ,
        PRECHARGE,
        REFRESH
    } state_t;

    localparam int mr_count = 7;

    // {bg, ba, addr} in load order, MR3 first
    localparam logic [17:0] mr_table [mr_count] = '{
        {2'd0, 2'd3, 14'h0000},
        {2'd1, 2'd2, 14'h080F},
        {2'd1, 2'd1, 14'h0400},
        {2'd1, 2'd0, 14'h1000},
        {2'd0, 2'd2, 14'h0088},
        {2'd0, 2'd1, 14'h0001},
        {2'd0, 2'd0, 14'h041D}
    };

endpackage

`default_nettype wire

// File: control_unit/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import dram_pkg::*; #(
    parameter int t_init = 8,
    parameter int t_mrd  = 4,
    parameter int t_rcd  = 3,
    parameter int t_rp   = 3,
    parameter int t_rfc  = 6,
    parameter int t_refi = 200
) (
    input  wire logic  CLK,
    input  wire logic  arst_n,
    input  wire logic  start,
    input  wire logic  op,
    input  wire row_t  row,
    input  wire bank_t bank,
    input  wire bg_t   bg,
    input  wire col_t  col,
    output state_t     state,
    output logic       issue,
    output logic       rf_all,
    output logic       busy,
    output logic       done,
    output row_t       row_q,
    output bank_t      bank_q,
    output bg_t        bg_q,
    output col_t       col_q
);

    state_t      state_n;
    logic [15:0] cnt;
    logic        cnt_zero;
    logic        pend;
    logic        op_q;
    logic        init_done;
    logic        rf_req;
    logic        rf_ack;
    logic        accept;
    logic        acc_end;

    // dwell of each state in cycles, minus one
    function automatic logic [15:0] dwell(state_t s);
        case (s)
            POWER_UP, PRE_RESET, RESET: dwell = 16'(t_init - 1);
            ACTIVATE, WRITE, READ:      dwell = 16'(t_rcd - 1);
            PRECHARGE:                  dwell = 16'(t_rp - 1);
            REFRESH:                    dwell = 16'(t_rfc - 1);
            default:                    dwell = 16'(t_mrd - 1);
        endcase
    endfunction

    refresh_timer #(
        .t_refi (t_refi)
    ) refresh_timer_inst (
        .CLK    (CLK),
        .arst_n (arst_n),
        .enable (init_done),
        .ack    (rf_ack),
        .rf_req (rf_req)
    );

    assign cnt_zero = (cnt == 16'd0);
    assign accept   = start && !busy;
    // refresh wins over a waiting start
    assign rf_ack   = (state == IDLE) && rf_req;
    assign acc_end  = (state == PRECHARGE) && cnt_zero && !rf_all;

    always_comb begin
        state_n = state;
        case (state)
            POWER_UP:      if (cnt_zero) state_n = PRE_RESET;
            PRE_RESET:     if (cnt_zero) state_n = RESET;
            RESET:         if (cnt_zero) state_n = NOP;
            NOP:           if (cnt_zero) state_n = LOAD_BG0_REG3;
            LOAD_BG0_REG3: if (cnt_zero) state_n = LOAD_BG1_REG6;
            LOAD_BG1_REG6: if (cnt_zero) state_n = LOAD_BG1_REG5;
            LOAD_BG1_REG5: if (cnt_zero) state_n = LOAD_BG1_REG4;
            LOAD_BG1_REG4: if (cnt_zero) state_n = LOAD_BG0_REG2;
            LOAD_BG0_REG2: if (cnt_zero) state_n = LOAD_BG0_REG1;
            LOAD_BG0_REG1: if (cnt_zero) state_n = LOAD_BG0_REG0;
            LOAD_BG0_REG0: if (cnt_zero) state_n = ZQ_CL;
            ZQ_CL:         if (cnt_zero) state_n = IDLE;
            IDLE: begin
                if (rf_req) begin
                    state_n = PRECHARGE;
                end else if (pend) begin
                    state_n = ACTIVATE;
                end
            end
            ACTIVATE:      if (cnt_zero) state_n = op_q ? WRITE : READ;
            WRITE, READ:   if (cnt_zero) state_n = PRECHARGE;
            PRECHARGE:     if (cnt_zero) state_n = rf_all ? REFRESH : IDLE;
            REFRESH:       if (cnt_zero) state_n = IDLE;
            default:       state_n = POWER_UP;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state     <= POWER_UP;
            cnt       <= dwell(POWER_UP);
            issue     <= 1'b0;
            done      <= 1'b0;
            busy      <= 1'b0;
            pend      <= 1'b0;
            rf_all    <= 1'b0;
            init_done <= 1'b0;
        end else begin
            state <= state_n;
            if (state_n != state) begin
                cnt <= dwell(state_n);
            end else if (!cnt_zero) begin
                cnt <= cnt - 16'd1;
            end
            issue <= (state_n != state) &&
                     !(state_n inside {PRE_RESET, RESET, NOP, IDLE});
            done  <= acc_end;
            if (accept) begin
                busy <= 1'b1;
            end else if (acc_end) begin
                busy <= 1'b0;
            end
            // start seen during init or refresh waits here
            if (accept) begin
                pend <= 1'b1;
            end else if (state == IDLE && state_n == ACTIVATE) begin
                pend <= 1'b0;
            end
            if (state == IDLE) begin
                rf_all <= rf_req;
            end
            if (state_n == IDLE) begin
                init_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            row_q  <= row;
            bank_q <= bank;
            bg_q   <= bg;
            col_q  <= col;
            op_q   <= op;
        end
    end

endmodule

`default_nettype wire

// File: control_unit/refresh_timer.sv
`timescale 1ns/1ps
`default_nettype none

module refresh_timer #(
    parameter int t_refi = 200
) (
    input  wire logic CLK,
    input  wire logic arst_n,
    input  wire logic enable,
    input  wire logic ack,
    output logic      rf_req
);

    logic [$clog2(t_refi + 1)-1:0] cnt;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            cnt    <= '0;
            rf_req <= 1'b0;
        end else if (rf_req) begin
            // held until served, count restarts from zero
            if (ack) begin
                rf_req <= 1'b0;
            end
        end else if (enable) begin
            if (cnt == ($bits(cnt))'(t_refi - 1)) begin
                cnt    <= '0;
                rf_req <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
common/dram_pkg.sv
source/apb_cmd_regs.sv
control_unit/refresh_timer.sv
control_unit/control_unit.sv
signal_gen/signal_gen.sv
source/dram_cmd_top.sv
verification/dram_cmd_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dram_cmd_tb \
    -f filelist.f -o dram_cmd_sim

./obj_dir/dram_cmd_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log

// File: signal_gen/signal_gen.sv
`timescale 1ns/1ps
`default_nettype none

module signal_gen import dram_pkg::*; (
    input  wire logic   CLK,
    input  wire logic   arst_n,
    input  wire state_t state,
    input  wire logic   issue,
    input  wire logic   rf_all,
    input  wire row_t   row_q,
    input  wire bank_t  bank_q,
    input  wire bg_t    bg_q,
    input  wire col_t   col_q,
    output logic        cs_n,
    output logic        act_n,
    output logic        ras_n_a16,
    output logic        cas_n_a15,
    output logic        we_n_a14,
    output bg_t         bg_pin,
    output bank_t       ba_pin,
    output addr_t       addr,
    output logic        cke,
    output logic        reset_n,
    output logic        odt,
    output logic        pwr,
    output logic        vref_ca,
    output logic        vref_dq
);

    logic [4:0] cmd_d;
    bg_t        bg_d;
    bank_t      ba_d;
    addr_t      addr_d;
    logic       cke_d;
    logic       reset_n_d;
    logic       pwr_d;
    logic       vref_d;
    logic [2:0] mr_idx;

    assign mr_idx = 3'(state - LOAD_BG0_REG3);

    always_comb begin
        cmd_d     = DESEL_CMD;
        bg_d      = '0;
        ba_d      = '0;
        addr_d    = '0;
        cke_d     = 1'b1;
        reset_n_d = 1'b1;
        pwr_d     = 1'b1;
        vref_d    = 1'b1;
        case (state)
            POWER_UP: begin
                // supplies and references still off
                cmd_d     = POWER_UP_PRG;
                cke_d     = 1'b0;
                reset_n_d = 1'b0;
                pwr_d     = 1'b0;
                vref_d    = 1'b0;
            end
            PRE_RESET: begin
                cmd_d     = POWER_UP_PRG;
                cke_d     = 1'b0;
                reset_n_d = 1'b0;
            end
            RESET: begin
                cmd_d = POWER_UP_PRG;
                cke_d = 1'b0;
            end
            LOAD_BG0_REG3, LOAD_BG1_REG6, LOAD_BG1_REG5, LOAD_BG1_REG4,
            LOAD_BG0_REG2, LOAD_BG0_REG1, LOAD_BG0_REG0: begin
                if (issue) begin
                    cmd_d                  = LOAD_MODE_CMD;
                    {bg_d, ba_d, addr_d}   = mr_table[mr_idx];
                end
            end
            ZQ_CL: begin
                if (issue) begin
                    cmd_d  = ZQ_CMD;
                    addr_d = 14'h0400;
                end
            end
            ACTIVATE: begin
                if (issue) begin
                    // row bit 14 rides on WE_n_A14
                    cmd_d  = {ACT_CMD[4:1], row_q[14]};
                    bg_d   = bg_q;
                    ba_d   = bank_q;
                    addr_d = row_q[13:0];
                end
            end
            WRITE, READ: begin
                if (issue) begin
                    cmd_d  = (state == WRITE) ? WRITE_CMD : READ_CMD;
                    bg_d   = bg_q;
                    ba_d   = bank_q;
                    addr_d = {2'b01, 2'b00, col_q};
                end
            end
            PRECHARGE: begin
                if (issue) begin
                    cmd_d      = PRECHARGE_CMD;
                    bg_d       = bg_q;
                    ba_d       = bank_q;
                    addr_d[10] = rf_all;
                end
            end
            REFRESH: begin
                if (issue) begin
                    cmd_d = REFRESH_CMD;
                end
            end
            default: cmd_d = DESEL_CMD;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14} <= POWER_UP_PRG;
            bg_pin  <= '0;
            ba_pin  <= '0;
            addr    <= '0;
            cke     <= 1'b0;
            reset_n <= 1'b0;
            odt     <= 1'b0;
            pwr     <= 1'b0;
            vref_ca <= 1'b0;
            vref_dq <= 1'b0;
        end else begin
            {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14} <= cmd_d;
            bg_pin  <= bg_d;
            ba_pin  <= ba_d;
            addr    <= addr_d;
            cke     <= cke_d;
            reset_n <= reset_n_d;
            odt     <= 1'b0;
            pwr     <= pwr_d;
            vref_ca <= vref_d;
            vref_dq <= vref_d;
        end
    end

endmodule

`default_nettype wire

// File: source/apb_cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_cmd_regs import dram_pkg::*; (
    input  wire logic        CLK,
    input  wire logic        arst_n,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [7:0]  paddr,
    input  wire logic [31:0] pwdata,
    input  wire logic        busy,
    input  wire logic        done,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output row_t             row,
    output bank_t            bank,
    output bg_t              bg,
    output col_t             col,
    output logic             op,
    output logic             start
);

    logic        access;
    logic        addr_ok;
    logic        wr_en;
    logic [15:0] acc_cnt;

    assign access  = psel && penable;
    assign addr_ok = (paddr == 8'h00) || (paddr == 8'h04) || (paddr == 8'h08) ||
                     (paddr == 8'h0C);
    // register writes locked out while an access runs
    assign wr_en   = access && pwrite && !busy;

    assign pready  = 1'b1;
    assign pslverr = access && !addr_ok;
    assign start   = wr_en && (paddr == 8'h08) && pwdata[0];

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            row  <= '0;
            bank <= '0;
            bg   <= '0;
            col  <= '0;
            op   <= 1'b0;
        end else if (wr_en) begin
            if (paddr == 8'h00) begin
                row  <= pwdata[14:0];
                bank <= pwdata[16:15];
                bg   <= pwdata[18:17];
            end else if (paddr == 8'h04) begin
                col <= pwdata[9:0];
                op  <= pwdata[16];
            end
        end
    end

    // completed accesses
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            acc_cnt <= '0;
        end else if (done) begin
            acc_cnt <= acc_cnt + 16'd1;
        end
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                8'h00: prdata = {13'd0, bg, bank, row};
                8'h04: prdata = {15'd0, op, 6'd0, col};
                8'h0C: prdata = {acc_cnt, 15'd0, busy};
                default: prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/dram_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module dram_cmd_top import dram_pkg::*; #(
    parameter int t_init = 8,
    parameter int t_mrd  = 4,
    parameter int t_rcd  = 3,
    parameter int t_rp   = 3,
    parameter int t_rfc  = 6,
    parameter int t_refi = 200
) (
    input  wire logic        CLK,
    input  wire logic        arst_n,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [7:0]  paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             cs_n,
    output logic             act_n,
    output logic             ras_n_a16,
    output logic             cas_n_a15,
    output logic             we_n_a14,
    output bg_t              bg_pin,
    output bank_t            ba_pin,
    output addr_t            addr,
    output logic             cke,
    output logic             reset_n,
    output logic             odt,
    output logic             pwr,
    output logic             vref_ca,
    output logic             vref_dq
);

    row_t   row, row_q;
    bank_t  bank, bank_q;
    bg_t    bg, bg_q;
    col_t   col, col_q;
    logic   op, start, busy, done, issue, rf_all;
    state_t state;

    apb_cmd_regs apb_cmd_regs_inst (
        .CLK (CLK), .arst_n (arst_n), .psel (psel), .penable (penable),
        .pwrite (pwrite), .paddr (paddr), .pwdata (pwdata), .busy (busy),
        .done (done), .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .row (row), .bank (bank), .bg (bg), .col (col), .op (op), .start (start)
    );

    control_unit #(
        .t_init (t_init), .t_mrd (t_mrd), .t_rcd (t_rcd),
        .t_rp (t_rp), .t_rfc (t_rfc), .t_refi (t_refi)
    ) control_unit_inst (
        .CLK (CLK), .arst_n (arst_n), .start (start), .op (op), .row (row),
        .bank (bank), .bg (bg), .col (col), .state (state), .issue (issue),
        .rf_all (rf_all), .busy (busy), .done (done), .row_q (row_q),
        .bank_q (bank_q), .bg_q (bg_q), .col_q (col_q)
    );

    signal_gen signal_gen_inst (
        .CLK (CLK), .arst_n (arst_n), .state (state), .issue (issue),
        .rf_all (rf_all), .row_q (row_q), .bank_q (bank_q), .bg_q (bg_q),
        .col_q (col_q), .cs_n (cs_n), .act_n (act_n), .ras_n_a16 (ras_n_a16),
        .cas_n_a15 (cas_n_a15), .we_n_a14 (we_n_a14), .bg_pin (bg_pin),
        .ba_pin (ba_pin), .addr (addr), .cke (cke), .reset_n (reset_n),
        .odt (odt), .pwr (pwr), .vref_ca (vref_ca), .vref_dq (vref_dq)
    );

endmodule

`default_nettype wire

// File: verification/dram_cmd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dram_cmd_tb import dram_pkg::*;;

    localparam int t_mrd  = 4;
    localparam int t_rcd  = 3;
    localparam int t_rp   = 3;
    localparam int t_refi = 300;

    logic        CLK = 1'b0;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        cs_n;
    logic        act_n;
    logic        ras_n_a16;
    logic        cas_n_a15;
    logic        we_n_a14;
    bg_t         bg_pin;
    bank_t       ba_pin;
    addr_t       addr;
    logic        cke;
    logic        reset_n;
    logic        odt;
    logic        pwr;
    logic        vref_ca;
    logic        vref_dq;

    // {cmd pins, bg, ba, addr} per command seen on the bus
    logic [22:0] cmd_q[$];
    int          cyc_q[$];
    int          cycle = 0;

    logic [31:0] rd;
    logic        err;
    int          prev_cyc;
    int          this_cyc;
    logic [17:0] mr;

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle <= cycle + 1;
    end

    dram_cmd_top #(
        .t_refi (t_refi)
    ) dram_cmd_top_inst (
        .CLK (CLK), .arst_n (arst_n), .psel (psel), .penable (penable),
        .pwrite (pwrite), .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
        .pready (pready), .pslverr (pslverr), .cs_n (cs_n), .act_n (act_n),
        .ras_n_a16 (ras_n_a16), .cas_n_a15 (cas_n_a15), .we_n_a14 (we_n_a14),
        .bg_pin (bg_pin), .ba_pin (ba_pin), .addr (addr), .cke (cke),
        .reset_n (reset_n), .odt (odt), .pwr (pwr), .vref_ca (vref_ca),
        .vref_dq (vref_dq)
    );

    // command monitor samples mid-cycle where the pins are stable
    always @(negedge CLK) begin
        if (arst_n && !cs_n) begin
            cmd_q.push_back({cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14,
                             bg_pin, ba_pin, addr});
            cyc_q.push_back(cycle);
        end
    end

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // every command lasts a single cycle
    cmd_one_cycle: assert property (@(posedge CLK) disable iff (!arst_n) !cs_n |=> cs_n)
    else begin
        $display("** Error at time %0t: cs_n = 0, expected 1", $time);
        abort_run();
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got == exp) else begin
            $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_gap(input string name, input int got, input int min_gap);
        assert (got >= min_gap) else begin
            $display("** Error at time %0t: %s = %0d cycles, expected at least %0d",
                     $time, name, got, min_gap);
            abort_run();
        end
    endtask

    task automatic check_reset_pins();
        check_val("cke", 32'(cke), 32'd0);
        check_val("reset_n", 32'(reset_n), 32'd0);
        check_val("odt", 32'(odt), 32'd0);
        check_val("command pins", 32'({cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14}),
                  32'(POWER_UP_PRG));
        check_val("pslverr", 32'(pslverr), 32'd0);
    endtask

    task automatic check_active_pins();
        check_val("cke", 32'(cke), 32'd1);
        check_val("reset_n", 32'(reset_n), 32'd1);
        check_val("odt", 32'(odt), 32'd0);
        check_val("pwr", 32'(pwr), 32'd1);
        check_val("vref_ca", 32'(vref_ca), 32'd1);
        check_val("vref_dq", 32'(vref_dq), 32'd1);
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] a, input logic [31:0] wd,
                              output logic [31:0] data, output logic slverr);
        int waited;
        waited = 0;
        @(posedge CLK);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = wd;
        @(posedge CLK);
        #2;
        penable = 1'b1;
        @(negedge CLK);
        while (!pready && waited < 16) begin
            @(negedge CLK);
            waited++;
        end
        if (!pready) begin
            $display("APB transfer to 0x%0h never saw pready", a);
            abort_run();
        end
        data   = prdata;
        slverr = pslverr;
        @(posedge CLK);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [31:0] wd);
        logic [31:0] data;
        logic        slverr;
        apb_access(1'b1, a, wd, data, slverr);
        check_val("pslverr", 32'(slverr), 32'd0);
    endtask

    task automatic load_access(input row_t r, input bank_t ba, input bg_t b_g,
                               input col_t c, input logic wr);
        write_reg(8'h00, {13'd0, b_g, ba, r});
        write_reg(8'h04, {15'd0, wr, 6'd0, c});
    endtask

    task automatic wait_cmds(input int n, input int limit);
        int waited;
        waited = 0;
        while (cmd_q.size() < n && waited < limit) begin
            @(negedge CLK);
            waited++;
        end
        if (cmd_q.size() < n) begin
            $display("no DRAM command arrived within %0d cycles", limit);
            abort_run();
        end
    endtask

    task automatic expect_cmd(input string what, input logic [4:0] cmd, input bg_t b_g,
                              input bank_t ba, input addr_t a, input logic check_bank,
                              output int cyc);
        logic [22:0] item;
        wait_cmds(1, 800);
        item = cmd_q.pop_front();
        cyc  = cyc_q.pop_front();
        check_val({what, " command pins"}, 32'(item[22:18]), 32'(cmd));
        if (check_bank) begin
            check_val({what, " bg_pin"}, 32'(item[17:16]), 32'(b_g));
            check_val({what, " ba_pin"}, 32'(item[15:14]), 32'(ba));
        end
        check_val({what, " addr"}, 32'(item[13:0]), 32'(a));
    endtask

    task automatic check_access(input row_t r, input bank_t ba, input bg_t b_g,
                                input col_t c, input logic wr);
        int         act_cyc;
        int         col_cyc;
        int         pre_cyc;
        string      col_name;
        logic [4:0] col_cmd;
        if (wr) begin
            col_name = "WRITE";
            col_cmd  = WRITE_CMD;
        end else begin
            col_name = "READ";
            col_cmd  = READ_CMD;
        end
        // CS_n and ACT_n low with row bits 16..14 on the other three
        expect_cmd("ACT", {4'b0000, r[14]}, b_g, ba, r[13:0], 1'b1, act_cyc);
        expect_cmd(col_name, col_cmd, b_g, ba, 14'h1000 | 14'(c), 1'b1, col_cyc);
        check_gap("ACT to column spacing", col_cyc - act_cyc, t_rcd);
        expect_cmd("PRECHARGE", PRECHARGE_CMD, b_g, ba, 14'h0000, 1'b1, pre_cyc);
    endtask

    task automatic wait_idle();
        logic [31:0] data;
        logic        slverr;
        int          polls;
        polls = 0;
        apb_access(1'b0, 8'h0C, 32'd0, data, slverr);
        while (data[0] && polls < 100) begin
            apb_access(1'b0, 8'h0C, 32'd0, data, slverr);
            polls++;
        end
        if (data[0]) begin
            $display("busy still set after %0d status polls", polls);
            abort_run();
        end
    endtask

    task automatic check_count(input int exp);
        logic [31:0] data;
        logic        slverr;
        apb_access(1'b0, 8'h0C, 32'd0, data, slverr);
        check_val("access counter", 32'(data[31:16]), 32'(exp));
        check_val("busy", 32'(data[0]), 32'd0);
    endtask

    initial begin
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;

        for (int i = 0; i < 4; i++) begin
            @(negedge CLK);
            check_reset_pins();
        end
        @(posedge CLK);
        #2;
        arst_n = 1'b1;
        @(negedge CLK);
        check_reset_pins();
        check_count(0);

        // mode register loads from MR3 down to MR0 and then ZQ
        for (int i = 0; i < mr_count; i++) begin
            mr = mr_table[i];
            expect_cmd("LOAD_MODE", LOAD_MODE_CMD, mr[17:16], mr[15:14], mr[13:0],
                       1'b1, this_cyc);
            if (i > 0) begin
                check_gap("mode load spacing", this_cyc - prev_cyc, t_mrd);
            end
            prev_cyc = this_cyc;
        end
        expect_cmd("ZQ", ZQ_CMD, 2'd0, 2'd0, 14'h0400, 1'b1, this_cyc);
        check_active_pins();

        load_access(15'h4A5C, 2'd2, 2'd1, 10'h1F3, 1'b1);
        write_reg(8'h08, 32'd1);
        check_access(15'h4A5C, 2'd2, 2'd1, 10'h1F3, 1'b1);
        wait_idle();
        check_count(1);

        // second start lands while busy
        load_access(15'h1234, 2'd1, 2'd3, 10'h2AA, 1'b0);
        write_reg(8'h08, 32'd1);
        write_reg(8'h08, 32'd1);
        check_access(15'h1234, 2'd1, 2'd3, 10'h2AA, 1'b0);
        wait_idle();
        check_count(2);
        check_val("queued commands", 32'(cmd_q.size()), 32'd0);

        apb_access(1'b1, 8'h10, 32'hFFFF_FFFF, rd, err);
        check_val("pslverr on write to 0x10", 32'(err), 32'd1);
        apb_access(1'b0, 8'h10, 32'd0, rd, err);
        check_val("pslverr on read of 0x10", 32'(err), 32'd1);
        apb_access(1'b0, 8'h00, 32'd0, rd, err);
        check_val("prdata at 0x00", rd, {13'd0, 2'd3, 2'd1, 15'h1234});
        apb_access(1'b0, 8'h04, 32'd0, rd, err);
        check_val("prdata at 0x04", rd, {15'd0, 1'b0, 6'd0, 10'h2AA});
        apb_access(1'b0, 8'h0C, 32'd0, rd, err);
        check_val("prdata at 0x0C", rd, {16'd2, 15'd0, 1'b0});

        // periodic refresh with an access started inside it
        load_access(15'h0321, 2'd3, 2'd2, 10'h055, 1'b1);
        expect_cmd("refresh PRECHARGE", PRECHARGE_CMD, 2'd0, 2'd0, 14'h0400, 1'b0, prev_cyc);
        write_reg(8'h08, 32'd1);
        expect_cmd("REFRESH", REFRESH_CMD, 2'd0, 2'd0, 14'h0000, 1'b1, this_cyc);
        check_gap("PRECHARGE to REFRESH spacing", this_cyc - prev_cyc, t_rp);
        check_access(15'h0321, 2'd3, 2'd2, 10'h055, 1'b1);
        wait_idle();
        check_count(3);
        check_val("queued commands", 32'(cmd_q.size()), 32'd0);
        check_active_pins();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
